//--- bscPkg.sv
package bscPkg;

	typedef logic [31:0] addrT;
	typedef logic [26:0] extAddrT;
	typedef logic [31:0] dataT;
	typedef logic [3:0] byteEnT;
	typedef logic [1:0] areaT;
	typedef logic [1:0] sizeT;
	typedef logic [1:0] waitSelT;
	typedef logic [4:0] regOffsetT;

	typedef logic [15:0] bcr1T;     // Long waits at [11:10] areas 2/3, [9:8] area 1, [7:6] area 0
	typedef logic [15:0] bcr2T;     // Widths at [7:6] area 3, [5:4] area 2, [3:2] area 1
	typedef logic [15:0] wcrT;      // Wait field of area n at [2n+1:2n]
	typedef logic [15:0] mcrT;      // Bit 2 enables refresh
	typedef logic [15:0] rtcsrT;    // Clock select at [5:3]
	typedef logic [7:0] rtcntT;
	typedef logic [7:0] rtcorT;

	localparam sizeT sizeByte = 2'b01;
	localparam sizeT sizeWord = 2'b10;
	localparam sizeT sizeLong = 2'b11;

	localparam addrT regBase = 32'hFFFF_FFE0;
	localparam logic [15:0] regKey = 16'hA55A;

	// Address bits 31:27, bit 29 selects the cache-through mirror
	localparam logic [4:0] extSpacePattern = 5'b00000;
	localparam logic [4:0] extSpaceMask = 5'b11011;

	localparam regOffsetT offBcr1 = 5'h00;
	localparam regOffsetT offBcr2 = 5'h04;
	localparam regOffsetT offWcr = 5'h08;
	localparam regOffsetT offMcr = 5'h0C;
	localparam regOffsetT offRtcsr = 5'h10;
	localparam regOffsetT offRtcnt = 5'h14;
	localparam regOffsetT offRtcor = 5'h18;

	localparam bcr1T bcr1Reset = 16'h03C0;
	localparam bcr1T bcr1WrMask = 16'h0FC0;
	localparam bcr1T bcr1RdMask = 16'h0FC0;
	localparam bcr2T bcr2Reset = 16'h00FC;    // Areas 1 to 3 start as long
	localparam bcr2T bcr2WrMask = 16'h00FC;
	localparam bcr2T bcr2RdMask = 16'h00FC;
	localparam wcrT wcrReset = 16'h00FF;
	localparam wcrT wcrWrMask = 16'h00FF;
	localparam wcrT wcrRdMask = 16'h00FF;
	localparam mcrT mcrReset = 16'h0000;
	localparam mcrT mcrWrMask = 16'h0004;
	localparam mcrT mcrRdMask = 16'h0004;
	localparam rtcsrT rtcsrReset = 16'h0000;
	localparam rtcsrT rtcsrWrMask = 16'h0038;
	localparam rtcsrT rtcsrRdMask = 16'h0038;
	localparam rtcntT rtcntReset = 8'h00;
	localparam rtcntT rtcntWrMask = 8'hFF;
	localparam rtcntT rtcntRdMask = 8'hFF;
	localparam rtcorT rtcorReset = 8'h00;
	localparam rtcorT rtcorWrMask = 8'hFF;
	localparam rtcorT rtcorRdMask = 8'hFF;

endpackage

//--- bscCfgIf.sv
`timescale 1ns/1ps

interface bscCfgIf;
	import bscPkg::*;

	sizeT [3:0] areaSize;           // Area 0 follows the boot pins
	waitSelT [3:0] areaWait;
	waitSelT [3:0] areaLongWait;    // Only counts with wait field 3

	modport cfgSource (
		output areaSize,
		output areaWait,
		output areaLongWait
	);

	modport cfgSink (
		input areaSize,
		input areaWait,
		input areaLongWait
	);

endinterface

//--- bscLaneIf.sv
`timescale 1ns/1ps

interface bscLaneIf;
	import bscPkg::*;

	logic start;            // Request accepted
	logic cycleEnd;         // T2 of the current external cycle
	logic lastCycle;
	logic [1:0] addrLow;
	byteEnT cycleWe;        // Lane strobes, active high
	dataT cycleData;

	modport laneCtrl (
		output start,
		output cycleEnd,
		input lastCycle,
		input addrLow,
		input cycleWe,
		input cycleData
	);

	modport laneData (
		input start,
		input cycleEnd,
		output lastCycle,
		output addrLow,
		output cycleWe,
		output cycleData
	);

endinterface

//--- bscControlRegs.sv
`timescale 1ns/1ps

module bscControlRegs (
	input  logic CLK,
	input  logic RST_N,
	input  bscPkg::addrT cpuAddr,
	input  bscPkg::dataT cpuWrData,
	input  logic cpuWe,
	input  logic cpuReq,
	input  bscPkg::sizeT bootMode,
	input  logic [6:0] prescaleTicks,
	input  bscPkg::dataT laneRdData,
	input  logic refreshTaken,
	output logic refreshReq,
	output bscPkg::dataT cpuRdData,
	bscCfgIf.cfgSource cfg
);
	import bscPkg::*;

	bcr1T bcr1;
	bcr2T bcr2;
	wcrT wcr;
	mcrT mcr;
	rtcsrT rtcsr;
	rtcntT rtcnt;
	rtcorT rtcor;

	logic regSel;
	logic regWrite;
	logic regRead;
	regOffsetT regOffset;
	logic [2:0] clkSel;
	logic tickSel;
	logic tickPrev;
	logic tick;
	rtcntT cntNext;
	logic [15:0] regRdValue;
	dataT regRdBuf;
	logic rdFromRegs;

	assign regSel = cpuAddr >= regBase;
	assign regOffset = {cpuAddr[4:2], 2'b00};
	assign regWrite = cpuReq && cpuWe && regSel && (cpuWrData[31:16] == regKey);
	assign regRead = cpuReq && !cpuWe && regSel;

	assign clkSel = rtcsr[5:3];
	assign tickSel = (clkSel == 3'd0) ? 1'b0 : prescaleTicks[clkSel - 3'd1];
	assign tick = tickSel && !tickPrev;     // Rising edge of the selected tap
	assign cntNext = rtcnt + 8'd1;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			bcr1 <= bcr1Reset;
			bcr2 <= bcr2Reset;
			wcr <= wcrReset;
			mcr <= mcrReset;
			rtcsr <= rtcsrReset;
			rtcnt <= rtcntReset;
			rtcor <= rtcorReset;
			tickPrev <= 1'b0;
			refreshReq <= 1'b0;
			rdFromRegs <= 1'b0;
		end else begin
			tickPrev <= tickSel;
			if (refreshTaken) begin
				refreshReq <= 1'b0;
			end
			if (tick) begin
				if (cntNext == rtcor) begin
					rtcnt <= '0;
					if (mcr[2]) begin       // Refresh enable
						refreshReq <= 1'b1;
					end
				end else begin
					rtcnt <= cntNext;
				end
			end
			if (regWrite) begin
				case (regOffset)
					offBcr1: bcr1 <= cpuWrData[15:0] & bcr1WrMask;
					offBcr2: bcr2 <= cpuWrData[15:0] & bcr2WrMask;
					offWcr: wcr <= cpuWrData[15:0] & wcrWrMask;
					offMcr: mcr <= cpuWrData[15:0] & mcrWrMask;
					offRtcsr: rtcsr <= cpuWrData[15:0] & rtcsrWrMask;
					offRtcnt: rtcnt <= cpuWrData[7:0] & rtcntWrMask;
					offRtcor: rtcor <= cpuWrData[7:0] & rtcorWrMask;
					default: ;
				endcase
			end
			if (cpuReq && !cpuWe) begin
				rdFromRegs <= regSel;       // Source of the last read
			end
		end
	end

	always_comb begin
		case (regOffset)
			offBcr1: regRdValue = bcr1 & bcr1RdMask;
			offBcr2: regRdValue = bcr2 & bcr2RdMask;
			offWcr: regRdValue = wcr & wcrRdMask;
			offMcr: regRdValue = mcr & mcrRdMask;
			offRtcsr: regRdValue = rtcsr & rtcsrRdMask;
			offRtcnt: regRdValue = {8'h00, rtcnt & rtcntRdMask};
			offRtcor: regRdValue = {8'h00, rtcor & rtcorRdMask};
			default: regRdValue = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (regRead) begin
			regRdBuf <= {16'h0000, regRdValue};
		end
	end

	assign cpuRdData = rdFromRegs ? regRdBuf : laneRdData;

	assign cfg.areaSize = {bcr2[7:6], bcr2[5:4], bcr2[3:2], sizeT'(bootMode + 2'd1)};
	assign cfg.areaWait = wcr[7:0];
	assign cfg.areaLongWait = {bcr1[11:10], bcr1[11:10], bcr1[9:8], bcr1[7:6]};

endmodule

//--- bscCycleSequencer.sv
`timescale 1ns/1ps

module bscCycleSequencer (
	input  logic CLK,
	input  logic RST_N,
	input  bscPkg::addrT cpuAddr,
	input  logic cpuWe,
	input  logic cpuReq,
	input  logic waitN,
	input  logic refreshReq,
	output logic cpuBusy,
	output logic refreshTaken,
	output bscPkg::extAddrT addr,
	output logic busStartN,
	output logic [3:0] chipSelN,
	output logic rdWrN,
	output logic rdN,
	output bscPkg::byteEnT weN,
	output logic rfs,
	output bscPkg::dataT dataOut,
	bscCfgIf.cfgSink cfg,
	bscLaneIf.laneCtrl lane
);
	import bscPkg::*;

	typedef enum logic [2:0] {
		T0,
		T1,
		TW,
		T2,
		TRFS1,
		TRFS2
	} busStateT;

	busStateT state;
	logic [2:0] waitCnt;
	logic [1:0] rfsCnt;
	logic [24:0] addrHi;
	logic weLatch;
	areaT area;
	logic extReq;
	logic accept;
	logic inCycle;
	logic strobeOn;
	logic [2:0] waitLoad;

	function automatic logic [2:0] waitCycles(input waitSelT waitSel, input waitSelT longWait);
		logic [2:0] cycles;
		case (waitSel)
			2'd0: cycles = 3'd0;
			2'd1: cycles = 3'd1;
			2'd2: cycles = 3'd2;
			default: cycles = 3'd3 + {1'b0, longWait};
		endcase
		return cycles;
	endfunction

	assign extReq = cpuReq && ((cpuAddr[31:27] & extSpaceMask) == extSpacePattern);
	assign accept = (state == T0) && extReq && !refreshReq;
	assign refreshTaken = (state == T0) && refreshReq;     // Refresh wins over the CPU
	assign area = addrHi[24:23];
	assign waitLoad = waitCycles(cfg.areaWait[area], cfg.areaLongWait[area]);

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state <= T0;
			waitCnt <= '0;
			rfsCnt <= '0;
		end else begin
			case (state)
				T0: begin
					if (refreshReq) begin
						rfsCnt <= 2'd3;
						state <= TRFS1;
					end else if (accept) begin
						state <= T1;
					end
				end
				T1: begin
					if (waitLoad == 3'd0) begin
						state <= T2;
					end else begin
						waitCnt <= waitLoad - 3'd1;
						state <= TW;
					end
				end
				TW: begin
					if (waitCnt != 3'd0) begin
						waitCnt <= waitCnt - 3'd1;
					end else if (waitN) begin   // External stretch after counted waits
						state <= T2;
					end
				end
				T2: state <= lane.lastCycle ? T0 : T1;
				TRFS1: begin
					if (rfsCnt != 2'd0) begin
						rfsCnt <= rfsCnt - 2'd1;
					end else begin
						state <= TRFS2;
					end
				end
				TRFS2: state <= T0;
				default: state <= T0;
			endcase
		end
	end

	always_ff @(posedge CLK) begin
		if (accept) begin
			addrHi <= cpuAddr[26:2];
			weLatch <= cpuWe;
		end
	end

	assign inCycle = state inside {T1, TW, T2};
	assign strobeOn = state inside {T1, TW};    // Strobes drop in T2

	assign lane.start = accept;
	assign lane.cycleEnd = state == T2;

	assign cpuBusy = extReq && !((state == T2) && lane.lastCycle);

	assign addr = {addrHi, lane.addrLow};
	assign busStartN = state != T1;
	assign chipSelN = inCycle ? ~(4'b0001 << area) : 4'b1111;
	assign rdWrN = !(inCycle && weLatch);
	assign rdN = !(strobeOn && !weLatch);
	assign weN = (strobeOn && weLatch) ? ~lane.cycleWe : 4'b1111;
	assign dataOut = (inCycle && weLatch) ? lane.cycleData : '0;

	// Second and fourth refresh cycle
	assign rfs = (state == TRFS1) && !rfsCnt[0];

endmodule

//--- bscLaneSteer.sv
`timescale 1ns/1ps

module bscLaneSteer #(
	parameter bit byteSizeEn = 1'b1,
	parameter bit wordSizeEn = 1'b1
) (
	input  logic CLK,
	input  logic RST_N,
	input  bscPkg::addrT cpuAddr,
	input  bscPkg::dataT cpuWrData,
	input  bscPkg::byteEnT cpuByteEn,
	input  logic cpuWe,
	input  bscPkg::dataT dataIn,
	output bscPkg::dataT laneRdData,
	bscCfgIf.cfgSink cfg,
	bscLaneIf.laneData lane
);
	import bscPkg::*;

	sizeT portSize;
	sizeT reqSize;
	logic [1:0] chunk;
	logic [1:0] firstChunk;
	logic [2:0] nextOff;
	logic weL;
	byteEnT byteEnL;
	byteEnT shiftedBe;
	byteEnT restBe;
	dataT wrDataL;
	dataT shiftedWr;
	dataT rdBuf;
	dataT placed;
	dataT laneMask;
	dataT merged;

	function automatic sizeT effSize(input sizeT code);
		sizeT res;
		case (code)
			sizeByte: res = byteSizeEn ? sizeByte : sizeLong;
			sizeWord: res = wordSizeEn ? sizeWord : sizeLong;
			default: res = sizeLong;
		endcase
		return res;
	endfunction

	assign reqSize = effSize(cfg.areaSize[cpuAddr[26:25]]);

	always_comb begin
		case (reqSize)
			sizeByte: firstChunk = cpuAddr[1:0];
			sizeWord: firstChunk = {cpuAddr[1], 1'b0};
			default: firstChunk = 2'b00;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			chunk <= '0;
			portSize <= sizeLong;
			weL <= 1'b0;
		end else if (lane.start) begin
			chunk <= firstChunk;
			portSize <= reqSize;
			weL <= cpuWe;
		end else if (lane.cycleEnd && !lane.lastCycle) begin
			chunk <= nextOff[1:0];
		end
	end

	always_ff @(posedge CLK) begin
		if (lane.start) begin
			byteEnL <= cpuByteEn;
			wrDataL <= cpuWrData;
			rdBuf <= '0;
		end else if (lane.cycleEnd && !weL) begin
			rdBuf <= merged;
		end
	end

	// Byte offset 0 is bits 31:24, so shifting left brings the chunk to the top
	assign shiftedWr = wrDataL << {chunk, 3'b000};
	assign shiftedBe = byteEnL << chunk;

	always_comb begin
		case (portSize)
			sizeByte: begin
				nextOff = {1'b0, chunk} + 3'd1;
				lane.cycleData = {24'h000000, shiftedWr[31:24]};
				lane.cycleWe = {3'b000, shiftedBe[3]};
				placed = {dataIn[7:0], 24'h000000} >> {chunk, 3'b000};
				laneMask = 32'hFF00_0000 >> {chunk, 3'b000};
			end
			sizeWord: begin
				nextOff = {1'b0, chunk} + 3'd2;
				lane.cycleData = {16'h0000, shiftedWr[31:16]};
				lane.cycleWe = {2'b00, shiftedBe[3:2]};
				placed = {dataIn[15:0], 16'h0000} >> {chunk, 3'b000};
				laneMask = 32'hFFFF_0000 >> {chunk, 3'b000};
			end
			default: begin
				nextOff = {1'b0, chunk} + 3'd4;
				lane.cycleData = shiftedWr;
				lane.cycleWe = shiftedBe;
				placed = dataIn;
				laneMask = 32'hFFFF_FFFF;
			end
		endcase
	end

	assign restBe = byteEnL << nextOff[1:0];    // Enabled bytes past this chunk
	assign lane.lastCycle = nextOff[2] || (restBe == 4'b0000);
	assign lane.addrLow = chunk;

	assign merged = (rdBuf & ~laneMask) | (placed & laneMask);
	assign laneRdData = (lane.cycleEnd && !weL) ? merged : rdBuf;

endmodule

//--- bscTop.sv
`timescale 1ns/1ps

module bscTop #(
	parameter bit byteSizeEn = 1'b1,
	parameter bit wordSizeEn = 1'b1
) (
	input  logic CLK,
	input  logic RST_N,
	input  bscPkg::addrT cpuAddr,
	input  bscPkg::dataT cpuWrData,
	input  bscPkg::byteEnT cpuByteEn,
	input  logic cpuWe,
	input  logic cpuReq,
	input  logic [6:0] prescaleTicks,
	input  logic [1:0] bootMode,
	input  bscPkg::dataT dataIn,
	input  logic waitN,
	output bscPkg::dataT cpuRdData,
	output logic cpuBusy,
	output bscPkg::extAddrT addr,
	output bscPkg::dataT dataOut,
	output logic busStartN,
	output logic [3:0] chipSelN,
	output logic rdWrN,
	output logic rdN,
	output bscPkg::byteEnT weN,
	output logic rfs
);
	import bscPkg::*;

	dataT laneRdData;
	logic refreshReq;
	logic refreshTaken;

	bscCfgIf cfgBus ();
	bscLaneIf laneBus ();

	bscControlRegs regs (
		.CLK(CLK),
		.RST_N(RST_N),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuWe(cpuWe),
		.cpuReq(cpuReq),
		.bootMode(bootMode),
		.prescaleTicks(prescaleTicks),
		.laneRdData(laneRdData),
		.refreshTaken(refreshTaken),
		.refreshReq(refreshReq),
		.cpuRdData(cpuRdData),
		.cfg(cfgBus.cfgSource)
	);

	bscCycleSequencer seq (
		.CLK(CLK),
		.RST_N(RST_N),
		.cpuAddr(cpuAddr),
		.cpuWe(cpuWe),
		.cpuReq(cpuReq),
		.waitN(waitN),
		.refreshReq(refreshReq),
		.cpuBusy(cpuBusy),
		.refreshTaken(refreshTaken),
		.addr(addr),
		.busStartN(busStartN),
		.chipSelN(chipSelN),
		.rdWrN(rdWrN),
		.rdN(rdN),
		.weN(weN),
		.rfs(rfs),
		.dataOut(dataOut),
		.cfg(cfgBus.cfgSink),
		.lane(laneBus.laneCtrl)
	);

	bscLaneSteer #(
		.byteSizeEn(byteSizeEn),
		.wordSizeEn(wordSizeEn)
	) steer (
		.CLK(CLK),
		.RST_N(RST_N),
		.cpuAddr(cpuAddr),
		.cpuWrData(cpuWrData),
		.cpuByteEn(cpuByteEn),
		.cpuWe(cpuWe),
		.dataIn(dataIn),
		.laneRdData(laneRdData),
		.cfg(cfgBus.cfgSink),
		.lane(laneBus.laneData)
	);

endmodule

//--- tbSramModel.sv
`timescale 1ns/1ps

module tbSramModel (
	input  logic CLK,
	input  bscPkg::extAddrT addr,
	input  bscPkg::dataT dataOut,
	input  logic busStartN,
	input  logic [3:0] chipSelN,
	input  logic rdWrN,
	input  logic rdN,
	input  bscPkg::byteEnT weN,
	input  logic rfs,
	input  logic [3:0][2:0] areaBytes,
	input  logic [3:0] waitHold,
	input  logic clr,
	output bscPkg::dataT dataIn,
	output logic waitN,
	output integer cycles,
	output logic [7:0] addrLog,
	output bscPkg::byteEnT wrMask,
	output integer rfsCount
);
	import bscPkg::*;

	logic [7:0] mem [0:1023];       // Area in bits 9:8, low address byte below
	logic [3:0] waitLeft;
	logic rfsPrev;
	logic [9:0] base;
	logic [2:0] width;
	logic sel;
	logic [9:0] wrIdx;
	dataT rdWord;

	assign base = {addr[26:25], addr[7:0]};
	assign width = areaBytes[addr[26:25]];
	assign sel = chipSelN == ~(4'b0001 << addr[26:25]);    // Only the addressed area
	assign waitN = !((!busStartN && waitHold != 4'd0) || waitLeft != 4'd0);

	// Lane j of a w-byte port holds byte w-1-j
	function automatic logic [9:0] laneIndex(input int j);
		return base + 10'(int'(width) - 1 - j);
	endfunction

	initial begin
		for (int i = 0; i < 1024; i++) begin
			mem[i] = 8'(i * 37 + (i >> 8) * 101 + 5);
		end
		waitLeft = 4'd0;
		rfsPrev = 1'b0;
		cycles = 0;
		addrLog = 8'h00;
		wrMask = 4'b0000;
		rfsCount = 0;
		dataIn = '0;
	end

	always_comb begin
		rdWord = '0;
		for (int j = 0; j < 4; j++) begin
			if (j < int'(width)) begin
				rdWord[8*j +: 8] = mem[laneIndex(j)];
			end
		end
	end

	always @(posedge CLK) begin
		rfsPrev <= rfs;
		if (rfs && !rfsPrev) begin
			rfsCount <= rfsCount + 1;
		end
		if (!busStartN) begin
			waitLeft <= (waitHold != 4'd0) ? waitHold - 4'd1 : 4'd0;
			if (sel) begin
				cycles <= cycles + 1;
				addrLog <= {addrLog[5:0], addr[1:0]};
			end
		end else if (waitLeft != 4'd0) begin
			waitLeft <= waitLeft - 4'd1;
		end
		if (sel && rdWrN && !rdN) begin
			dataIn <= rdWord;       // Held through T2
		end
		for (int j = 0; j < 4; j++) begin
			wrIdx = laneIndex(j);
			if (j < int'(width) && sel && !rdWrN && rdN && !weN[j]) begin
				mem[wrIdx] <= dataOut[8*j +: 8];
				wrMask[2'd3 - wrIdx[1:0]] <= 1'b1;     // Bit 3 is offset 0
			end
		end
		if (clr) begin
			cycles <= 0;
			addrLog <= 8'h00;
			wrMask <= 4'b0000;
		end
	end

endmodule

//--- tbBsc.sv
`timescale 1ns/1ps

module tbBsc;
	import bscPkg::*;

	logic CLK;
	logic RST_N;
	addrT cpuAddr;
	dataT cpuWrData;
	byteEnT cpuByteEn;
	logic cpuWe;
	logic cpuReq;
	logic [6:0] prescaleTicks;
	logic [1:0] bootMode;
	dataT dataIn;
	logic waitN;
	dataT cpuRdData;
	logic cpuBusy;
	extAddrT addr;
	dataT dataOut;
	logic busStartN;
	logic [3:0] chipSelN;
	logic rdWrN;
	logic rdN;
	byteEnT weN;
	logic rfs;

	logic [3:0][2:0] areaBytes;
	logic [3:0] waitHold;
	logic clr;
	integer cycles;
	logic [7:0] addrLog;
	byteEnT wrMask;
	integer rfsCount;
	logic [31:0] seed;

	bscTop dut (
		.CLK(CLK), .RST_N(RST_N), .cpuAddr(cpuAddr), .cpuWrData(cpuWrData),
		.cpuByteEn(cpuByteEn), .cpuWe(cpuWe), .cpuReq(cpuReq),
		.prescaleTicks(prescaleTicks), .bootMode(bootMode), .dataIn(dataIn),
		.waitN(waitN), .cpuRdData(cpuRdData), .cpuBusy(cpuBusy), .addr(addr),
		.dataOut(dataOut), .busStartN(busStartN), .chipSelN(chipSelN),
		.rdWrN(rdWrN), .rdN(rdN), .weN(weN), .rfs(rfs)
	);

	tbSramModel model (
		.CLK(CLK), .addr(addr), .dataOut(dataOut), .busStartN(busStartN),
		.chipSelN(chipSelN), .rdWrN(rdWrN), .rdN(rdN),
		.weN(weN), .rfs(rfs), .areaBytes(areaBytes), .waitHold(waitHold),
		.clr(clr), .dataIn(dataIn), .waitN(waitN), .cycles(cycles),
		.addrLog(addrLog), .wrMask(wrMask), .rfsCount(rfsCount)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	// Free-running prescaler taps
	always begin
		@(posedge CLK);
		#1;
		prescaleTicks = prescaleTicks + 7'd1;
	end

	function automatic dataT lcgNext();
		seed = seed * 32'd1103515245 + 32'd12345;
		return seed;
	endfunction

	function automatic dataT memWord(input addrT a);
		logic [9:0] idx;
		idx = {a[26:25], a[7:0]};
		return {model.mem[idx], model.mem[idx + 10'd1], model.mem[idx + 10'd2],
			model.mem[idx + 10'd3]};
	endfunction

	// Counted waits, then waitN stretch beyond them
	function automatic integer expectedLatency(input integer field, input integer longWait,
		input integer k);
		integer n;
		n = (field < 3) ? field : 3 + longWait;
		return 3 + n + ((k > n) ? k - n : 0);
	endfunction

	task automatic failStop(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping on first error");
	endtask

	task automatic checkData(input string name, input dataT exp, input dataT act);
		if (exp !== act) begin
			failStop($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic checkCount(input string name, input integer exp, input integer act);
		if (exp !== act) begin
			failStop($sformatf("MISMATCH %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic checkByteEn(input string name, input byteEnT exp, input byteEnT act);
		if (exp !== act) begin
			failStop($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
		end
	endtask

	// Register accesses finish in their request cycle
	task automatic regAccess(input regOffsetT off, input logic we, input dataT wdata,
		output dataT rdata);
		cpuAddr = regBase | addrT'(off);
		cpuWe = we;
		cpuWrData = wdata;
		cpuReq = 1'b1;
		@(negedge CLK);
		if (cpuBusy) begin
			failStop("register access raised cpuBusy");
		end
		@(posedge CLK);
		#1;
		cpuReq = 1'b0;
		rdata = cpuRdData;
	endtask

	task automatic regWrite(input regOffsetT off, input logic [15:0] value);
		dataT unused;
		regAccess(off, 1'b1, {regKey, value}, unused);
	endtask

	task automatic extAccess(input string name, input addrT a, input logic we,
		input dataT wdata, input byteEnT be, output dataT rdata, output integer lat);
		logic done;
		cpuAddr = a;
		cpuWe = we;
		cpuWrData = wdata;
		cpuByteEn = be;
		cpuReq = 1'b1;
		lat = 0;
		done = 1'b0;
		rdata = '0;
		while (!done) begin
			@(negedge CLK);
			lat = lat + 1;
			if (!cpuBusy) begin
				done = 1'b1;
				rdata = cpuRdData;
			end else if (lat > 200) begin
				failStop({name, ": timeout waiting for cpuBusy to drop"});
			end
		end
		@(posedge CLK);
		#1;
		cpuReq = 1'b0;
	endtask

	task automatic clearCounters();
		clr = 1'b1;
		@(posedge CLK);
		#1;
		clr = 1'b0;
	endtask

	task automatic waitRfs(input integer target);
		integer guard;
		guard = 0;
		while (rfsCount < target) begin
			@(negedge CLK);
			guard = guard + 1;
			if (guard > 100) begin
				failStop("timeout waiting for a refresh strobe");
			end
		end
	endtask

	task automatic testRegisters();
		dataT rd;
		regWrite(offWcr, 16'h12C6);
		regAccess(offWcr, 1'b0, '0, rd);
		checkData("wcr keyed write", 32'h0000_00C6, rd);
		regAccess(offWcr, 1'b1, 32'h0000_0033, rd);
		regAccess(offWcr, 1'b0, '0, rd);
		checkData("wcr write without key", 32'h0000_00C6, rd);
		regWrite(offRtcor, 16'hBEEF);
		regAccess(offRtcor, 1'b0, '0, rd);
		checkData("rtcor keyed write", 32'h0000_00EF, rd);
		regWrite(offBcr1, 16'hFFFF);
		regAccess(offBcr1, 1'b0, '0, rd);
		checkData("bcr1 masked", 32'h0000_0FC0, rd);
		// Area 1 long, area 2 byte, area 3 word, no waits
		regWrite(offBcr1, 16'h0000);
		regWrite(offBcr2, 16'h009C);
		regWrite(offWcr, 16'h0003);
		regWrite(offRtcor, 16'h0000);
	endtask

	task automatic testLongArea();
		dataT wd;
		dataT rd;
		integer lat;
		wd = lcgNext();
		extAccess("long write", 32'h0200_0040, 1'b1, wd, 4'b1111, rd, lat);
		checkCount("long write latency", 3, lat);
		checkData("long write memory", wd, memWord(32'h0200_0040));
		extAccess("long read", 32'h0200_0040, 1'b0, '0, 4'b1111, rd, lat);
		checkCount("long read latency", 3, lat);
		checkData("long read data", wd, rd);
		extAccess("long read fill", 32'h0200_0080, 1'b0, '0, 4'b1111, rd, lat);
		checkData("long read fill data", memWord(32'h0200_0080), rd);
	endtask

	task automatic testWaitStates();
		dataT rd;
		integer lat;
		regWrite(offWcr, 16'h000B);
		waitHold = 4'd4;
		extAccess("wait field 2", 32'h0200_0040, 1'b0, '0, 4'b1111, rd, lat);
		checkCount("wait field 2 latency", expectedLatency(2, 0, 4), lat);
		checkData("wait field 2 data", memWord(32'h0200_0040), rd);
		regWrite(offWcr, 16'h000F);
		regWrite(offBcr1, 16'h0100);
		waitHold = 4'd6;
		extAccess("long wait", 32'h0200_0040, 1'b0, '0, 4'b1111, rd, lat);
		checkCount("long wait latency", expectedLatency(3, 1, 6), lat);
		checkData("long wait data", memWord(32'h0200_0040), rd);
		waitHold = 4'd0;
		regWrite(offWcr, 16'h0003);
		regWrite(offBcr1, 16'h0000);
	endtask

	task automatic testNarrowAreas();
		dataT wd;
		dataT pd;
		dataT merged;
		dataT rd;
		integer lat;
		wd = lcgNext();
		clearCounters();
		extAccess("byte area write", 32'h0400_0010, 1'b1, wd, 4'b1111, rd, lat);
		checkCount("byte area write cycles", 4, cycles);
		checkCount("byte area addr order", 32'h1B, integer'(addrLog));
		checkByteEn("byte area write strobes", 4'b1111, wrMask);
		checkData("byte area write memory", wd, memWord(32'h0400_0010));
		pd = lcgNext();
		merged = {wd[31:24], pd[23:8], wd[7:0]};
		clearCounters();
		extAccess("byte area partial", 32'h0400_0010, 1'b1, pd, 4'b0110, rd, lat);
		checkCount("byte area partial cycles", 3, cycles);
		checkByteEn("byte area partial strobes", 4'b0110, wrMask);
		clearCounters();
		extAccess("byte area read", 32'h0400_0010, 1'b0, '0, 4'b1111, rd, lat);
		checkCount("byte area read cycles", 4, cycles);
		checkData("byte area read data", merged, rd);
		clearCounters();
		extAccess("word area read", 32'h0600_0020, 1'b0, '0, 4'b1111, rd, lat);
		checkCount("word area read cycles", 2, cycles);
		checkData("word area read data", memWord(32'h0600_0020), rd);
	endtask

	task automatic testRefresh();
		integer base;
		dataT rd;
		integer lat;
		regWrite(offRtcor, 16'h0004);
		regWrite(offMcr, 16'h0004);
		base = rfsCount;
		regWrite(offRtcsr, 16'h0010);   // Tap 1, one match every 16 cycles
		waitRfs(base + 2);
		base = rfsCount;
		repeat (72) @(posedge CLK);
		#1;
		checkCount("refresh pulses in window", 8, rfsCount - base);
		waitRfs(rfsCount + 1);
		@(posedge CLK);
		#1;
		extAccess("read during refresh", 32'h0200_0040, 1'b0, '0, 4'b1111, rd, lat);
		checkData("read during refresh data", memWord(32'h0200_0040), rd);
		if (lat <= 3) begin
			failStop("request during refresh was not held off");
		end
		regWrite(offMcr, 16'h0000);
		regWrite(offRtcsr, 16'h0000);
	endtask

	initial begin
		seed = 32'd15;
		RST_N = 1'b0;
		cpuAddr = '0;
		cpuWrData = '0;
		cpuByteEn = 4'b0000;
		cpuWe = 1'b0;
		cpuReq = 1'b0;
		prescaleTicks = 7'd0;
		bootMode = 2'b10;               // Area 0 long
		areaBytes = {3'd2, 3'd1, 3'd4, 3'd4};
		waitHold = 4'd0;
		clr = 1'b0;
		repeat (8) @(posedge CLK);
		#1;
		RST_N = 1'b1;
		@(posedge CLK);
		#1;
		testRegisters();
		testLongArea();
		testWaitStates();
		testNarrowAreas();
		testRefresh();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- build.f
bscPkg.sv
bscCfgIf.sv
bscLaneIf.sv
bscControlRegs.sv
bscCycleSequencer.sv
bscLaneSteer.sv
bscTop.sv
tbSramModel.sv
tbBsc.sv

//--- runSim.sh
#!/bin/bash
# Compile and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tbBsc -f build.f -o simBsc > build.log 2>&1 \
	|| { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/simBsc > sim.log 2>&1
grep -q "ALL TESTS PASSED" sim.log && echo "Simulation passed" \
	|| { echo "Simulation failed, see sim.log"; exit 1; }
